// ==== sim.f ====
hdl/backend_pkg.sv
hdl/arch_regfile.sv
hdl/rename_stage.sv
hdl/reorder_buffer.sv
hdl/alu_issue.sv
hdl/commit_stage.sv
hdl/backend_top.sv
tb/tb_backend_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_backend_top -f sim.f

out=$(./obj_dir/Vtb_backend_top 2>&1) || true
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== tb/tb_backend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_backend_top;
  import backend_pkg::*;

  localparam int ACCEPT_LIMIT = 200; // cycles per instruction
  localparam int DRAIN_LIMIT  = 500;

  logic        clk;
  logic        rst_n;
  logic        inst_valid_i;
  logic        inst_ready_o;
  alu_op_e     inst_op_i;
  arch_rid_t   inst_rd_i;
  arch_rid_t   inst_rs1_i;
  arch_rid_t   inst_rs2_i;
  logic        inst_use_imm_i;
  word_t       inst_imm_i;
  logic        commit_valid_o;
  arch_rid_t   commit_rd_o;
  word_t       commit_data_o;

  word_t       model_regs [ARCH_REGS];
  arch_rid_t   exp_rd_q [$];
  word_t       exp_data_q [$];
  logic [31:0] rng_state;
  int          accept_count;
  int          commit_count;
  int          stall_cycles;
  int          mismatch_errs;
  int          other_errs;

  backend_top UUT (
    .clk(clk), .rst_n(rst_n),
    .inst_valid_i(inst_valid_i), .inst_ready_o(inst_ready_o),
    .inst_op_i(inst_op_i), .inst_rd_i(inst_rd_i),
    .inst_rs1_i(inst_rs1_i), .inst_rs2_i(inst_rs2_i),
    .inst_use_imm_i(inst_use_imm_i), .inst_imm_i(inst_imm_i),
    .commit_valid_o(commit_valid_o), .commit_rd_o(commit_rd_o),
    .commit_data_o(commit_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // reference ALU
  function automatic word_t expected_result(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_rd(string name, arch_rid_t got, arch_rid_t exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_data(string name, word_t got, word_t exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // called 1 ns after a rising edge, returns at the same point
  task automatic send_inst(alu_op_e op, arch_rid_t rd, arch_rid_t rs1, arch_rid_t rs2,
                           logic use_imm, word_t imm);
    int    waited;
    word_t b;
    word_t res;
    waited         = 0;
    inst_valid_i   = 1'b1;
    inst_op_i      = op;
    inst_rd_i      = rd;
    inst_rs1_i     = rs1;
    inst_rs2_i     = rs2;
    inst_use_imm_i = use_imm;
    inst_imm_i     = imm;
    @(negedge clk);
    while (!inst_ready_o && waited < ACCEPT_LIMIT) begin
      stall_cycles++;
      waited++;
      @(negedge clk);
    end
    if (!inst_ready_o) begin
      other_errs++;
      $display("timeout: instruction %0d was never accepted", accept_count);
      end_run();
    end else begin
      @(posedge clk); // taken at this edge
      b   = use_imm ? imm : model_regs[rs2];
      res = expected_result(op, model_regs[rs1], b);
      if (rd != '0) begin
        model_regs[rd] = res;
      end
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(res);
      accept_count++;
      #1;
      inst_valid_i = 1'b0;
    end
  endtask

  task automatic random_mix(int n);
    logic [31:0] r;
    logic [31:0] gap;
    for (int i = 0; i < n; i++) begin
      r   = next_rand();
      gap = next_rand();
      send_inst(alu_op_e'(r[18:16]), r[22:19], r[26:23], r[30:27], r[31], next_rand());
      if (gap[17:16] == 2'd0) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // sources name the last one to three destinations
  task automatic dependent_chains(int n);
    logic [31:0] r;
    arch_rid_t   hist [3];
    arch_rid_t   rd;
    hist[0] = 4'd1;
    hist[1] = 4'd2;
    hist[2] = 4'd3;
    for (int i = 0; i < n; i++) begin
      r  = next_rand();
      rd = (r[23:20] == '0) ? 4'd5 : r[23:20];
      send_inst(alu_op_e'(r[28:26]), rd, hist[int'(r[17:16]) % 3],
                hist[int'(r[19:18]) % 3], r[24] & r[25], next_rand());
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = rd;
    end
  endtask

  task automatic zero_reg_reads(int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      send_inst(alu_op_e'(r[18:16]), 4'd0, r[22:19], r[26:23], r[27], next_rand());
      send_inst(ALU_OR, r[31:28], 4'd0, 4'd0, 1'b0, '0);
      send_inst(ALU_ADD, 4'd0, 4'd0, r[22:19], r[30], next_rand());
    end
  endtask

  task automatic dependent_burst(int n);
    logic [31:0] r;
    arch_rid_t   prev;
    arch_rid_t   rd;
    int          stalls_before;
    stalls_before = stall_cycles;
    prev          = 4'd7;
    for (int i = 0; i < n; i++) begin
      r  = next_rand();
      rd = arch_rid_t'(i % 15 + 1);
      send_inst(r[16] ? ALU_ADD : ALU_XOR, rd, prev, prev, 1'b0, '0);
      prev = rd;
    end
    if (stall_cycles == stalls_before) begin
      other_errs++;
      $display("inst_ready_o never fell during the dependent burst");
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (commit_count != accept_count && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (commit_count != accept_count) begin
      other_errs++;
      $display("timeout: %0d of %0d instructions committed", commit_count, accept_count);
    end
    repeat (8) @(negedge clk); // catch late extra commits
    if (exp_rd_q.size() != 0) begin
      other_errs++;
      $display("%0d expected results were never committed", exp_rd_q.size());
    end
  endtask

  // commit stream checker
  initial begin
    arch_rid_t exp_rd;
    word_t     exp_data;
    forever begin
      @(negedge clk);
      if (rst_n && commit_valid_o) begin
        commit_count++;
        if (exp_rd_q.size() == 0) begin
          other_errs++;
          $display("commit seen with no instruction outstanding");
        end else begin
          exp_rd   = exp_rd_q.pop_front();
          exp_data = exp_data_q.pop_front();
          check_rd("commit_rd_o", commit_rd_o, exp_rd);
          check_data("commit_data_o", commit_data_o, exp_data);
        end
      end
    end
  end

  initial begin
    rng_state      = 32'd26;
    accept_count   = 0;
    commit_count   = 0;
    stall_cycles   = 0;
    mismatch_errs  = 0;
    other_errs     = 0;
    for (int i = 0; i < ARCH_REGS; i++) begin
      model_regs[i] = '0;
    end
    rst_n          = 1'b0;
    inst_valid_i   = 1'b0;
    inst_op_i      = ALU_ADD;
    inst_rd_i      = '0;
    inst_rs1_i     = '0;
    inst_rs2_i     = '0;
    inst_use_imm_i = 1'b0;
    inst_imm_i     = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("inst_ready_o", inst_ready_o, 1'b1);
    check_flag("commit_valid_o", commit_valid_o, 1'b0);
    @(posedge clk);
    #1;
    random_mix(200);
    dependent_chains(60);
    zero_reg_reads(16);
    dependent_burst(24);
    wait_drain();
    end_run();
  end

endmodule

`default_nettype wire

// ==== hdl/backend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     inst_valid_i,
  output logic                    inst_ready_o,
  input  backend_pkg::alu_op_e    inst_op_i,
  input  backend_pkg::arch_rid_t  inst_rd_i,
  input  backend_pkg::arch_rid_t  inst_rs1_i,
  input  backend_pkg::arch_rid_t  inst_rs2_i,
  input  wire                     inst_use_imm_i,
  input  backend_pkg::word_t      inst_imm_i,
  output logic                    commit_valid_o,
  output backend_pkg::arch_rid_t  commit_rd_o,
  output backend_pkg::word_t      commit_data_o
);
  import backend_pkg::*;

  logic      rob_free;
  rob_id_t   tail_id;
  logic      slot_free;
  logic      disp_fire;
  arch_rid_t arf_raddr1;
  arch_rid_t arf_raddr2;
  word_t     arf_rdata1;
  word_t     arf_rdata2;
  rob_id_t   lookup_id1;
  rob_id_t   lookup_id2;
  logic      lookup_ready1;
  logic      lookup_ready2;
  word_t     lookup_data1;
  word_t     lookup_data2;
  logic      op1_ready;
  logic      op2_ready;
  word_t     op1;
  word_t     op2;
  rob_id_t   op1_tag;
  rob_id_t   op2_tag;
  logic      cdb_valid;   // result bus
  rob_id_t   cdb_rob_id;
  word_t     cdb_data;
  logic      head_done;
  rob_id_t   head_id;
  arch_rid_t head_rd;
  word_t     head_data;
  logic      retire_fire;
  rob_id_t   retire_rob_id;
  arch_rid_t retire_rd;
  word_t     retire_data;

  arch_regfile u_arf (
    .clk(clk), .rst_n(rst_n),
    .raddr1_i(arf_raddr1), .raddr2_i(arf_raddr2),
    .rdata1_o(arf_rdata1), .rdata2_o(arf_rdata2),
    .we_i(retire_fire), .waddr_i(retire_rd), .wdata_i(retire_data)
  );

  rename_stage u_rename (
    .clk(clk), .rst_n(rst_n),
    .inst_valid_i(inst_valid_i), .inst_op_i(inst_op_i), .inst_rd_i(inst_rd_i),
    .inst_rs1_i(inst_rs1_i), .inst_rs2_i(inst_rs2_i),
    .inst_use_imm_i(inst_use_imm_i), .inst_imm_i(inst_imm_i),
    .rob_free_i(rob_free), .tail_id_i(tail_id), .slot_free_i(slot_free),
    .inst_ready_o(inst_ready_o), .disp_fire_o(disp_fire),
    .arf_raddr1_o(arf_raddr1), .arf_raddr2_o(arf_raddr2),
    .arf_rdata1_i(arf_rdata1), .arf_rdata2_i(arf_rdata2),
    .lookup_id1_o(lookup_id1), .lookup_id2_o(lookup_id2),
    .lookup_ready1_i(lookup_ready1), .lookup_ready2_i(lookup_ready2),
    .lookup_data1_i(lookup_data1), .lookup_data2_i(lookup_data2),
    .op1_ready_o(op1_ready), .op2_ready_o(op2_ready), .op1_o(op1), .op2_o(op2),
    .op1_tag_o(op1_tag), .op2_tag_o(op2_tag),
    .retire_fire_i(retire_fire), .retire_rd_i(retire_rd), .retire_rob_id_i(retire_rob_id)
  );

  reorder_buffer u_rob (
    .clk(clk), .rst_n(rst_n),
    .disp_fire_i(disp_fire), .disp_rd_i(inst_rd_i),
    .tail_id_o(tail_id), .rob_free_o(rob_free),
    .cdb_valid_i(cdb_valid), .cdb_rob_id_i(cdb_rob_id), .cdb_data_i(cdb_data),
    .lookup_id1_i(lookup_id1), .lookup_id2_i(lookup_id2),
    .lookup_ready1_o(lookup_ready1), .lookup_ready2_o(lookup_ready2),
    .lookup_data1_o(lookup_data1), .lookup_data2_o(lookup_data2),
    .head_done_o(head_done), .head_id_o(head_id),
    .head_rd_o(head_rd), .head_data_o(head_data),
    .retire_i(retire_fire)
  );

  alu_issue u_alu (
    .clk(clk), .rst_n(rst_n),
    .load_i(disp_fire), .op_i(inst_op_i), .rob_id_i(tail_id),
    .op1_ready_i(op1_ready), .op2_ready_i(op2_ready), .op1_i(op1), .op2_i(op2),
    .op1_tag_i(op1_tag), .op2_tag_i(op2_tag),
    .slot_free_o(slot_free),
    .cdb_valid_o(cdb_valid), .cdb_rob_id_o(cdb_rob_id), .cdb_data_o(cdb_data)
  );

  commit_stage u_commit (
    .clk(clk), .rst_n(rst_n),
    .head_done_i(head_done), .head_id_i(head_id),
    .head_rd_i(head_rd), .head_data_i(head_data),
    .retire_o(retire_fire), .retire_rob_id_o(retire_rob_id),
    .retire_rd_o(retire_rd), .retire_data_o(retire_data),
    .commit_valid_o(commit_valid_o), .commit_rd_o(commit_rd_o),
    .commit_data_o(commit_data_o)
  );

endmodule

`default_nettype wire

// ==== hdl/commit_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_stage (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     head_done_i,
  input  backend_pkg::rob_id_t    head_id_i,
  input  backend_pkg::arch_rid_t  head_rd_i,
  input  backend_pkg::word_t      head_data_i,
  output logic                    retire_o,
  output backend_pkg::rob_id_t    retire_rob_id_o,
  output backend_pkg::arch_rid_t  retire_rd_o,
  output backend_pkg::word_t      retire_data_o,
  output logic                    commit_valid_o,
  output backend_pkg::arch_rid_t  commit_rd_o,
  output backend_pkg::word_t      commit_data_o
);
  import backend_pkg::*;

  // in-order retire, at most one per cycle
  assign retire_o        = head_done_i;
  assign retire_rob_id_o = head_id_i;
  assign retire_rd_o     = head_rd_i;
  assign retire_data_o   = head_data_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      commit_valid_o <= 1'b0;
    end else begin
      commit_valid_o <= retire_o;
    end
  end

  always_ff @(posedge clk) begin
    if (retire_o) begin
      commit_rd_o   <= head_rd_i;
      commit_data_o <= head_data_i;
    end
  end

  // rob head moves on by one with each commit
  a_commit_retired: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid_o |-> (head_id_i == rob_id_t'($past(head_id_i) + rob_id_t'(1))));

endmodule

`default_nettype wire

// ==== hdl/alu_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_issue (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    load_i,
  input  backend_pkg::alu_op_e   op_i,
  input  backend_pkg::rob_id_t   rob_id_i,
  input  wire                    op1_ready_i,
  input  wire                    op2_ready_i,
  input  backend_pkg::word_t     op1_i,
  input  backend_pkg::word_t     op2_i,
  input  backend_pkg::rob_id_t   op1_tag_i,
  input  backend_pkg::rob_id_t   op2_tag_i,
  output logic                   slot_free_o,
  output logic                   cdb_valid_o,
  output backend_pkg::rob_id_t   cdb_rob_id_o,
  output backend_pkg::word_t     cdb_data_o
);
  import backend_pkg::*;

  logic    valid_q;
  alu_op_e op_q;
  rob_id_t rob_q;
  word_t   a_q;
  word_t   b_q;
  logic    rdy1_q;
  logic    rdy2_q;
  rob_id_t tag1_q;
  rob_id_t tag2_q;
  logic    fire;
  word_t   alu_res;
  logic    wake1;
  logic    wake2;

  assign fire        = valid_q && rdy1_q && rdy2_q;
  assign slot_free_o = !valid_q || fire;

  // listen on the result bus, own results too
  assign wake1 = valid_q && !rdy1_q && cdb_valid_o && (cdb_rob_id_o == tag1_q);
  assign wake2 = valid_q && !rdy2_q && cdb_valid_o && (cdb_rob_id_o == tag2_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load_i) begin
      valid_q <= 1'b1;
    end else if (fire) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      op_q   <= op_i;
      rob_q  <= rob_id_i;
      a_q    <= op1_i;
      b_q    <= op2_i;
      rdy1_q <= op1_ready_i;
      rdy2_q <= op2_ready_i;
      tag1_q <= op1_tag_i;
      tag2_q <= op2_tag_i;
    end else begin
      if (wake1) begin
        a_q    <= cdb_data_o;
        rdy1_q <= 1'b1;
      end
      if (wake2) begin
        b_q    <= cdb_data_o;
        rdy2_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (op_q)
      ALU_ADD: alu_res = a_q + b_q;
      ALU_SUB: alu_res = a_q - b_q;
      ALU_AND: alu_res = a_q & b_q;
      ALU_OR:  alu_res = a_q | b_q;
      ALU_XOR: alu_res = a_q ^ b_q;
      ALU_SLL: alu_res = a_q << b_q[SHAMT_W-1:0];
      ALU_SRL: alu_res = a_q >> b_q[SHAMT_W-1:0];
      ALU_SLT: alu_res = word_t'($signed(a_q) < $signed(b_q));
      default: alu_res = '0;
    endcase
  end

  // result bus, one cycle after fire
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cdb_valid_o <= 1'b0;
    end else begin
      cdb_valid_o <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      cdb_rob_id_o <= rob_q;
      cdb_data_o   <= alu_res;
    end
  end

  a_no_load_busy: assert property (@(posedge clk) disable iff (!rst_n)
    load_i |-> slot_free_o);

endmodule

`default_nettype wire

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     disp_fire_i,
  input  backend_pkg::arch_rid_t  disp_rd_i,
  output backend_pkg::rob_id_t    tail_id_o,
  output logic                    rob_free_o,
  input  wire                     cdb_valid_i,
  input  backend_pkg::rob_id_t    cdb_rob_id_i,
  input  backend_pkg::word_t      cdb_data_i,
  input  backend_pkg::rob_id_t    lookup_id1_i,
  input  backend_pkg::rob_id_t    lookup_id2_i,
  output logic                    lookup_ready1_o,
  output logic                    lookup_ready2_o,
  output backend_pkg::word_t      lookup_data1_o,
  output backend_pkg::word_t      lookup_data2_o,
  output logic                    head_done_o,
  output backend_pkg::rob_id_t    head_id_o,
  output backend_pkg::arch_rid_t  head_rd_o,
  output backend_pkg::word_t      head_data_o,
  input  wire                     retire_i
);
  import backend_pkg::*;

  rob_id_t                head_q;
  rob_id_t                tail_q;
  logic [ROB_CNT_W-1:0]   count_q;
  logic [ROB_DEPTH-1:0]   done_q;
  arch_rid_t              rd_q    [ROB_DEPTH];
  word_t                  value_q [ROB_DEPTH];
  logic                   hit1;
  logic                   hit2;
  rob_id_t                cdb_off; // distance of cdb entry from head

  assign tail_id_o  = tail_q;
  assign rob_free_o = (count_q != ROB_CNT_W'(ROB_DEPTH));

  assign head_id_o   = head_q;
  assign head_rd_o   = rd_q[head_q];
  assign head_data_o = value_q[head_q];
  assign head_done_o = (count_q != '0) && done_q[head_q];

  // operand lookup with result bus bypass
  assign hit1 = cdb_valid_i && (cdb_rob_id_i == lookup_id1_i);
  assign hit2 = cdb_valid_i && (cdb_rob_id_i == lookup_id2_i);
  assign lookup_ready1_o = done_q[lookup_id1_i] || hit1;
  assign lookup_ready2_o = done_q[lookup_id2_i] || hit2;
  assign lookup_data1_o  = hit1 ? cdb_data_i : value_q[lookup_id1_i];
  assign lookup_data2_o  = hit2 ? cdb_data_i : value_q[lookup_id2_i];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (disp_fire_i) begin
        tail_q         <= tail_q + rob_id_t'(1);
        done_q[tail_q] <= 1'b0;
      end
      if (cdb_valid_i) begin
        done_q[cdb_rob_id_i] <= 1'b1;
      end
      if (retire_i) begin
        head_q <= head_q + rob_id_t'(1);
      end
      case ({disp_fire_i, retire_i})
        2'b10:   count_q <= count_q + ROB_CNT_W'(1);
        2'b01:   count_q <= count_q - ROB_CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (disp_fire_i) begin
      rd_q[tail_q] <= disp_rd_i;
    end
    if (cdb_valid_i) begin
      value_q[cdb_rob_id_i] <= cdb_data_i;
    end
  end

  assign cdb_off = cdb_rob_id_i - head_q;

  a_no_disp_full: assert property (@(posedge clk) disable iff (!rst_n)
    disp_fire_i |-> rob_free_o);

  a_cdb_live_entry: assert property (@(posedge clk) disable iff (!rst_n)
    cdb_valid_i |-> (ROB_CNT_W'(cdb_off) < count_q));

endmodule

`default_nettype wire

// ==== hdl/rename_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     inst_valid_i,
  input  backend_pkg::alu_op_e    inst_op_i,
  input  backend_pkg::arch_rid_t  inst_rd_i,
  input  backend_pkg::arch_rid_t  inst_rs1_i,
  input  backend_pkg::arch_rid_t  inst_rs2_i,
  input  wire                     inst_use_imm_i,
  input  backend_pkg::word_t      inst_imm_i,
  input  wire                     rob_free_i,
  input  backend_pkg::rob_id_t    tail_id_i,
  input  wire                     slot_free_i,
  output logic                    inst_ready_o,
  output logic                    disp_fire_o,
  output backend_pkg::arch_rid_t  arf_raddr1_o,
  output backend_pkg::arch_rid_t  arf_raddr2_o,
  input  backend_pkg::word_t      arf_rdata1_i,
  input  backend_pkg::word_t      arf_rdata2_i,
  output backend_pkg::rob_id_t    lookup_id1_o,
  output backend_pkg::rob_id_t    lookup_id2_o,
  input  wire                     lookup_ready1_i,
  input  wire                     lookup_ready2_i,
  input  backend_pkg::word_t      lookup_data1_i,
  input  backend_pkg::word_t      lookup_data2_i,
  output logic                    op1_ready_o,
  output logic                    op2_ready_o,
  output backend_pkg::word_t      op1_o,
  output backend_pkg::word_t      op2_o,
  output backend_pkg::rob_id_t    op1_tag_o,
  output backend_pkg::rob_id_t    op2_tag_o,
  input  wire                     retire_fire_i,
  input  backend_pkg::arch_rid_t  retire_rd_i,
  input  backend_pkg::rob_id_t    retire_rob_id_i
);
  import backend_pkg::*;

  logic [ARCH_REGS-1:0] pending_q;
  rob_id_t              tag_q [ARCH_REGS];

  assign inst_ready_o = rob_free_i && slot_free_i;
  assign disp_fire_o  = inst_valid_i && inst_ready_o;

  assign arf_raddr1_o = inst_rs1_i;
  assign arf_raddr2_o = inst_rs2_i;
  assign lookup_id1_o = tag_q[inst_rs1_i];
  assign lookup_id2_o = tag_q[inst_rs2_i];
  assign op1_tag_o    = tag_q[inst_rs1_i];
  assign op2_tag_o    = tag_q[inst_rs2_i];

  // pick arf value, or rob answer while the source is in flight
  always_comb begin
    op1_ready_o = 1'b1;
    op1_o       = arf_rdata1_i;
    if (pending_q[inst_rs1_i]) begin
      op1_ready_o = lookup_ready1_i;
      op1_o       = lookup_data1_i;
    end
    op2_ready_o = 1'b1;
    op2_o       = arf_rdata2_i;
    if (inst_use_imm_i) begin
      op2_o = inst_imm_i;
    end else if (pending_q[inst_rs2_i]) begin
      op2_ready_o = lookup_ready2_i;
      op2_o       = lookup_data2_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      if (retire_fire_i && tag_q[retire_rd_i] == retire_rob_id_i) begin
        pending_q[retire_rd_i] <= 1'b0;
      end
      if (disp_fire_o && inst_rd_i != '0) begin
        pending_q[inst_rd_i] <= 1'b1; // new rename wins over retire
      end
    end
  end

  always_ff @(posedge clk) begin
    if (disp_fire_o && inst_rd_i != '0) begin
      tag_q[inst_rd_i] <= tail_id_i;
    end
  end

  // upstream must hold the instruction until it is taken
  a_payload_hold: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i && !inst_ready_o |=>
      inst_valid_i && $stable({inst_op_i, inst_rd_i, inst_rs1_i, inst_rs2_i,
                               inst_use_imm_i, inst_imm_i}));

endmodule

`default_nettype wire

// ==== hdl/arch_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_regfile (
  input  wire                     clk,
  input  wire                     rst_n,
  input  backend_pkg::arch_rid_t  raddr1_i,
  input  backend_pkg::arch_rid_t  raddr2_i,
  output backend_pkg::word_t      rdata1_o,
  output backend_pkg::word_t      rdata2_o,
  input  wire                     we_i,
  input  backend_pkg::arch_rid_t  waddr_i,
  input  backend_pkg::word_t      wdata_i
);
  import backend_pkg::*;

  word_t regs_q [ARCH_REGS];
  logic  wr_en;

  assign wr_en = we_i && (waddr_i != '0); // r0 stays zero

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // same-cycle write is visible on the read ports
  assign rdata1_o = (wr_en && waddr_i == raddr1_i) ? wdata_i : regs_q[raddr1_i];
  assign rdata2_o = (wr_en && waddr_i == raddr2_i) ? wdata_i : regs_q[raddr2_i];

endmodule

`default_nettype wire

// ==== hdl/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

  // datapath and register widths
  localparam int XLEN      = 32;
  localparam int ARCH_REGS = 16;
  localparam int ROB_DEPTH = 8;

  localparam int REG_IDX_W = $clog2(ARCH_REGS);
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);
  localparam int ROB_CNT_W = ROB_IDX_W + 1; // holds 0..ROB_DEPTH
  localparam int SHAMT_W   = $clog2(XLEN);

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] arch_rid_t;
  typedef logic [ROB_IDX_W-1:0] rob_id_t;

  // integer ALU opcodes
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5, // shift by op2[4:0]
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7  // signed compare, 1 or 0
  } alu_op_e;

endpackage

`default_nettype wire
